//--- common/tmr_arb_pkg.sv
// sizes, index and payload types and the two-of-three voters that every arbiter RTL file imports
`default_nettype none

package tmr_arb_pkg;

  ////////////////////
  // sizes
  ////////////////////

  // eight requesters, so a three level selection tree
  localparam int unsigned num_in     = 8;
  localparam int unsigned idx_width  = 3;
  localparam int unsigned data_width = 16;
  // three lock-step copies of the arbitration logic
  localparam int unsigned num_lanes  = 3;

  typedef logic [idx_width-1:0]  idx_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [num_in-1:0]     req_vec_t;

  ////////////////////
  // voters
  ////////////////////

  // bitwise two-of-three majority on the widest vector in the design
  // the narrower wrappers below widen, vote and cut back to their own type
  function automatic data_t maj3(input data_t a, input data_t b, input data_t c);
    return (a & b) | (a & c) | (b & c);
  endfunction

  function automatic req_vec_t maj3_vec(input req_vec_t a, input req_vec_t b, input req_vec_t c);
    data_t v;
    v = maj3(data_t'(a), data_t'(b), data_t'(c));
    return req_vec_t'(v);
  endfunction

  function automatic idx_t maj3_idx(input idx_t a, input idx_t b, input idx_t c);
    data_t v;
    v = maj3(data_t'(a), data_t'(b), data_t'(c));
    return idx_t'(v);
  endfunction

  function automatic data_t maj3_data(input data_t a, input data_t b, input data_t c);
    return maj3(a, b, c);
  endfunction

  // single flags such as the lock bit and the output request go through here
  function automatic logic maj3_bit(input logic a, input logic b, input logic c);
    data_t v;
    v = maj3(data_t'(a), data_t'(b), data_t'(c));
    return v[0];
  endfunction

endpackage

`default_nettype wire

//--- arb_tree/arb_tree_lane.sv
// one redundant copy of the round-robin selection tree, instantiated once per lane by the top level
`timescale 1ns/1ps
`default_nettype none

module arb_tree_lane (
  // request vector after the lock stage, identical for all lanes
  input  tmr_arb_pkg::req_vec_t                         req_i,
  input  tmr_arb_pkg::data_t [tmr_arb_pkg::num_in-1:0]  data_i,
  // voted round-robin pointer, the msb steers the root
  input  tmr_arb_pkg::idx_t                             prio_i,
  input  logic                                          gnt_i,
  output logic                                          req_o,
  output tmr_arb_pkg::idx_t                             idx_o,
  output tmr_arb_pkg::data_t                            data_o,
  output tmr_arb_pkg::req_vec_t                         gnt_o
);
  import tmr_arb_pkg::*;

  // the tree is stored breadth first, node 0 is the root
  // a node at level lvl and position n sits at 2**lvl-1+n
  // its children sit at 2**(lvl+1)-1+2*n and the one after it
  logic  req_nodes  [num_in-1];
  idx_t  idx_nodes  [num_in-1];
  data_t data_nodes [num_in-1];
  logic  gnt_nodes  [num_in-1];

  ////////////////////
  // root
  ////////////////////

  // the decision of the whole lane is whatever reached the root
  assign req_o  = req_nodes[0];
  assign idx_o  = idx_nodes[0];
  assign data_o = data_nodes[0];

  // the downstream grant enters at the root and walks down the chosen path
  assign gnt_nodes[0] = gnt_i;

  ////////////////////
  // tree levels
  ////////////////////

  for (genvar lvl = 0; lvl < idx_width; lvl++) begin : gen_level
    for (genvar n = 0; n < 2**lvl; n++) begin : gen_node
      // high picks the right hand side of this node
      logic sel;

      if (lvl == idx_width - 1) begin : gen_leaf
        // bottom level, each node looks at two neighbouring requesters
        assign req_nodes[2**lvl-1+n] = req_i[2*n] | req_i[2*n+1];

        // go right when left is idle, or when both ask and the pointer bit points right
        assign sel = ~req_i[2*n] | (req_i[2*n+1] & prio_i[idx_width-1-lvl]);

        // the lsb of the index is born here
        assign idx_nodes[2**lvl-1+n]  = idx_t'(sel);
        assign data_nodes[2**lvl-1+n] = sel ? data_i[2*n+1] : data_i[2*n];

        // a grant only lands on a requester that is actually asking
        assign gnt_o[2*n]   = gnt_nodes[2**lvl-1+n] & req_i[2*n] & ~sel;
        assign gnt_o[2*n+1] = gnt_nodes[2**lvl-1+n] & req_i[2*n+1] & sel;
      end else begin : gen_inner
        // upper levels combine two subtrees of the level below
        assign req_nodes[2**lvl-1+n] = req_nodes[2**(lvl+1)-1+2*n]
                                     | req_nodes[2**(lvl+1)-1+2*n+1];

        assign sel = ~req_nodes[2**(lvl+1)-1+2*n]
                   | (req_nodes[2**(lvl+1)-1+2*n+1] & prio_i[idx_width-1-lvl]);

        // prepend the choice made here to the low index bits coming up from below
        assign idx_nodes[2**lvl-1+n] = sel ?
          idx_t'({1'b1, idx_nodes[2**(lvl+1)-1+2*n+1][idx_width-lvl-2:0]}) :
          idx_t'({1'b0, idx_nodes[2**(lvl+1)-1+2*n][idx_width-lvl-2:0]});

        assign data_nodes[2**lvl-1+n] = sel ? data_nodes[2**(lvl+1)-1+2*n+1]
                                            : data_nodes[2**(lvl+1)-1+2*n];

        // only the chosen child sees the grant
        assign gnt_nodes[2**(lvl+1)-1+2*n]   = gnt_nodes[2**lvl-1+n] & ~sel;
        assign gnt_nodes[2**(lvl+1)-1+2*n+1] = gnt_nodes[2**lvl-1+n] & sel;
      end
    end
  end

endmodule

`default_nettype wire

//--- arb_tree/rr_next_prio.sv
// fair next-pointer proposal for one lane, voted by the top level before the pointer register
`timescale 1ns/1ps
`default_nettype none

module rr_next_prio (
  input  tmr_arb_pkg::req_vec_t req_i,
  input  tmr_arb_pkg::idx_t     prio_i,
  // this lane's own output request, so each lane proposes from its own view
  input  logic                  lane_req_i,
  input  logic                  gnt_i,
  output tmr_arb_pkg::idx_t     prio_o
);
  import tmr_arb_pkg::*;

  req_vec_t upper_mask;
  req_vec_t lower_mask;
  idx_t     upper_idx;
  idx_t     lower_idx;
  idx_t     next_idx;
  logic     upper_empty;

  // position of the lowest set bit, zero for an empty vector
  // scanning downwards lets the lowest hit overwrite the others
  function automatic idx_t lowest_set(input req_vec_t vec);
    idx_t pos;
    pos = '0;
    for (int i = num_in - 1; i >= 0; i--) begin
      if (vec[i]) begin
        pos = idx_t'(i);
      end
    end
    return pos;
  endfunction

  // split the waiting requests around the current pointer
  always_comb begin
    for (int i = 0; i < num_in; i++) begin
      upper_mask[i] = (i > prio_i) ? req_i[i] : 1'b0;
      lower_mask[i] = (i <= prio_i) ? req_i[i] : 1'b0;
    end
  end

  assign upper_idx   = lowest_set(upper_mask);
  assign lower_idx   = lowest_set(lower_mask);
  assign upper_empty = ~|upper_mask;

  // jump to the next waiter above the pointer, wrap to the lowest waiter otherwise
  assign next_idx = upper_empty ? lower_idx : upper_idx;

  // the pointer only moves on a completed handshake
  assign prio_o = (lane_req_i && gnt_i) ? next_idx : prio_i;

endmodule

`default_nettype wire

//--- rtl/arb_lock_state.sv
// voted lock flag and captured request vector that hold an unserved decision until it is granted
`timescale 1ns/1ps
`default_nettype none

module arb_lock_state (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  input  tmr_arb_pkg::req_vec_t                 req_i,
  // output request of each of the three lanes
  input  logic [tmr_arb_pkg::num_lanes-1:0]     lane_req_i,
  input  logic                                  gnt_i,
  output tmr_arb_pkg::req_vec_t                 req_held_o
);
  import tmr_arb_pkg::*;

  logic                 lock_q;
  req_vec_t             req_q;
  logic [num_lanes-1:0] lock_d;
  req_vec_t             cap_d [num_lanes];
  logic                 lock_voted;
  req_vec_t             cap_voted;

  // while locked the lanes keep arbitrating over the frozen vector
  assign req_held_o = lock_q ? req_q : req_i;

  // each lane proposes a lock when it asked downstream and got no grant
  // its capture proposal is empty when it does not want to lock
  for (genvar l = 0; l < num_lanes; l++) begin : gen_lane_prop
    assign lock_d[l] = lane_req_i[l] & ~gnt_i;
    assign cap_d[l]  = lock_d[l] ? req_held_o : '0;
  end

  // a single upset lane cannot set or drop the lock on its own
  assign lock_voted = maj3_bit(lock_d[0], lock_d[1], lock_d[2]);
  assign cap_voted  = maj3_vec(cap_d[0], cap_d[1], cap_d[2]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= 1'b0;
      req_q  <= '0;
    end else if (flush_i) begin
      lock_q <= 1'b0;
      req_q  <= '0;
    end else begin
      lock_q <= lock_voted;
      req_q  <= cap_voted;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // the requesters may not withdraw a request that the lock still relies on
  locked_req_kept : assert property (
    @(posedge clk_i) disable iff (!rst_ni || flush_i)
    lock_q |-> ((req_i & req_q) == req_q))
    else $error("unserved request dropped while the arbiter decision is locked");

endmodule

`default_nettype wire

//--- rtl/tmr_rr_arb.sv
// top level of the triple redundant round-robin arbiter with single-rail request and grant ports
`timescale 1ns/1ps
`default_nettype none

module tmr_rr_arb (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         flush_i,
  input  tmr_arb_pkg::req_vec_t                        req_i,
  input  tmr_arb_pkg::data_t [tmr_arb_pkg::num_in-1:0] data_i,
  input  logic                                         gnt_i,
  output tmr_arb_pkg::req_vec_t                        gnt_o,
  output logic                                         req_o,
  output tmr_arb_pkg::data_t                           data_o,
  output tmr_arb_pkg::idx_t                            idx_o,
  // high whenever one lane disagrees with the vote
  output logic                                         fault_o
);
  import tmr_arb_pkg::*;

  req_vec_t             req_held;
  idx_t                 prio_q;
  idx_t                 prio_voted;
  logic [num_lanes-1:0] lane_req;
  idx_t                 lane_idx  [num_lanes];
  data_t                lane_data [num_lanes];
  req_vec_t             lane_gnt  [num_lanes];
  idx_t                 prio_next [num_lanes];
  logic                 fault;

  ////////////////////
  // lanes
  ////////////////////

  arb_lock_state arb_lock_state_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .req_i      (req_i),
    .lane_req_i (lane_req),
    .gnt_i      (gnt_i),
    .req_held_o (req_held)
  );

  // three identical copies run in lock step on the same inputs
  for (genvar l = 0; l < num_lanes; l++) begin : gen_lane
    arb_tree_lane arb_tree_lane_i (
      .req_i  (req_held),
      .data_i (data_i),
      .prio_i (prio_q),
      .gnt_i  (gnt_i),
      .req_o  (lane_req[l]),
      .idx_o  (lane_idx[l]),
      .data_o (lane_data[l]),
      .gnt_o  (lane_gnt[l])
    );

    rr_next_prio rr_next_prio_i (
      .req_i      (req_held),
      .prio_i     (prio_q),
      .lane_req_i (lane_req[l]),
      .gnt_i      (gnt_i),
      .prio_o     (prio_next[l])
    );
  end

  ////////////////////
  // voting
  ////////////////////

  // the pointer is voted before it is stored, so the register holds one clean copy
  assign prio_voted = maj3_idx(prio_next[0], prio_next[1], prio_next[2]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= '0;
    end else if (flush_i) begin
      prio_q <= '0;
    end else begin
      prio_q <= prio_voted;
    end
  end

  assign req_o  = maj3_bit(lane_req[0], lane_req[1], lane_req[2]);
  assign idx_o  = maj3_idx(lane_idx[0], lane_idx[1], lane_idx[2]);
  assign data_o = maj3_data(lane_data[0], lane_data[1], lane_data[2]);
  assign gnt_o  = maj3_vec(lane_gnt[0], lane_gnt[1], lane_gnt[2]);

  // any lane that differs from a voted field counts, pointer proposals included
  always_comb begin
    fault = 1'b0;
    for (int l = 0; l < num_lanes; l++) begin
      if ((lane_req[l] != req_o) || (lane_idx[l] != idx_o) || (lane_data[l] != data_o)
          || (lane_gnt[l] != gnt_o) || (prio_next[l] != prio_voted)) begin
        fault = 1'b1;
      end
    end
  end

  assign fault_o = fault;

  // at most one requester is granted per cycle
  gnt_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni || flush_i)
    $onehot0(gnt_o))
    else $error("more than one requester granted");

  // the lock stage never hides a live request from the tree
  req_passes : assert property (
    @(posedge clk_i) disable iff (!rst_ni || flush_i)
    (|req_i) |-> req_o)
    else $error("pending request did not reach the output");

endmodule

`default_nettype wire

//--- testbench/tb_vectors.svh
// stimulus rows for the arbiter testbench, included in the body of the testbench module
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns are test, req_i, gnt_i, flush_i, cycles to hold the row,
// then the req_o and idx_o expected in the first cycle of the row
task automatic load_vectors();
  // all eight ask with the grant held high, so each index wins once in turn
  add_row(1, 8'hff, 1'b1, 1'b0, 8, 1'b1, 3'd0);
  // requesters 1, 4 and 6 only, the pointer still sits at zero on entry
  add_row(2, 8'h52, 1'b1, 1'b0, 7, 1'b1, 3'd1);
  // clear the pointer, then stall a lone request at 5 while lower ones join
  add_row(3, 8'h00, 1'b0, 1'b1, 1, 1'b0, 3'd0);
  add_row(3, 8'h20, 1'b0, 1'b0, 3, 1'b1, 3'd5);
  add_row(3, 8'h25, 1'b0, 1'b0, 3, 1'b1, 3'd5);
  add_row(3, 8'h25, 1'b1, 1'b0, 1, 1'b1, 3'd5);
  // 5 was served and drops out, the pointer now sits at 5
  add_row(3, 8'h05, 1'b1, 1'b0, 2, 1'b1, 3'd0);
  // move the pointer away from zero, then flush while a grant is taken
  add_row(4, 8'hff, 1'b1, 1'b0, 3, 1'b1, 3'd2);
  add_row(4, 8'hff, 1'b1, 1'b1, 1, 1'b1, 3'd5);
  add_row(4, 8'hff, 1'b1, 1'b0, 2, 1'b1, 3'd0);
  // a flush also drops a locked decision
  add_row(4, 8'h80, 1'b0, 1'b0, 2, 1'b1, 3'd7);
  add_row(4, 8'h81, 1'b0, 1'b1, 1, 1'b1, 3'd7);
  add_row(4, 8'h03, 1'b1, 1'b0, 1, 1'b1, 3'd0);
  // idle arbiter, then a stalled pair that must not see any grant
  add_row(5, 8'h00, 1'b1, 1'b0, 2, 1'b0, 3'd0);
  add_row(5, 8'h0c, 1'b0, 1'b0, 2, 1'b1, 3'd3);
  add_row(5, 8'h0c, 1'b1, 1'b0, 1, 1'b1, 3'd3);
  add_row(5, 8'h00, 1'b0, 1'b0, 1, 1'b0, 3'd0);
endtask

`endif

//--- testbench/tb_tmr_rr_arb.sv
// self-checking testbench for the redundant round-robin arbiter, run on the included vector table
`timescale 1ns/1ps
`default_nettype none

module tb_tmr_rr_arb;
  import tmr_arb_pkg::*;

  localparam int unsigned clk_half     = 50;
  localparam int unsigned settle_limit = 10;

  logic                clk;
  logic                rst_n;
  logic                flush_in;
  req_vec_t            req_in;
  data_t [num_in-1:0]  data_in;
  logic                gnt_in;
  req_vec_t            gnt_out;
  logic                req_out;
  data_t               data_out;
  idx_t                idx_out;
  logic                fault;

  // the vector table, one entry per row
  int       row_test     [$];
  req_vec_t row_req      [$];
  logic     row_gnt      [$];
  logic     row_flush    [$];
  int       row_cycles   [$];
  logic     row_exp_req  [$];
  idx_t     row_exp_idx  [$];

  // state of the reference model, updated at every rising edge
  idx_t     model_prio;
  logic     model_lock;
  req_vec_t model_cap;

  integer seed;
  int     cur_test;
  int     errors_test;
  int     errors_total;
  int     fault_errors;
  int     cycles_checked;
  int     tests_run;
  int     tests_failed;
  logic   timed_out;

  tmr_rr_arb tmr_rr_arb_i (
    .clk_i   (clk),
    .rst_ni  (rst_n),
    .flush_i (flush_in),
    .req_i   (req_in),
    .data_i  (data_in),
    .gnt_i   (gnt_in),
    .gnt_o   (gnt_out),
    .req_o   (req_out),
    .data_o  (data_out),
    .idx_o   (idx_out),
    .fault_o (fault)
  );

  always #(clk_half) clk = ~clk;

  task automatic add_row(input int test, input req_vec_t req, input logic gnt, input logic flush,
                         input int cycles, input logic exp_req, input idx_t exp_idx);
    row_test.push_back(test);
    row_req.push_back(req);
    row_gnt.push_back(gnt);
    row_flush.push_back(flush);
    row_cycles.push_back(cycles);
    row_exp_req.push_back(exp_req);
    row_exp_idx.push_back(exp_idx);
  endtask

  `include "tb_vectors.svh"

  ////////////////////
  // reference model
  ////////////////////

  // walk the pointer bits from the msb, halving the requester range at each level
  function automatic idx_t pick_winner(input req_vec_t req, input idx_t prio);
    int   lo;
    int   size;
    logic left_any;
    logic right_any;
    lo   = 0;
    size = num_in;
    for (int lvl = 0; lvl < idx_width; lvl++) begin
      size      = size / 2;
      left_any  = 1'b0;
      right_any = 1'b0;
      for (int i = 0; i < size; i++) begin
        left_any  = left_any | req[lo+i];
        right_any = right_any | req[lo+size+i];
      end
      // the right half wins when the left is idle or the pointer bit leans right
      if (!left_any || (right_any && prio[idx_width-1-lvl])) begin
        lo = lo + size;
      end
    end
    return idx_t'(lo);
  endfunction

  // first waiter above the pointer, else the lowest waiter of all
  function automatic idx_t next_pointer(input req_vec_t req, input idx_t prio);
    idx_t nxt;
    logic found;
    nxt   = '0;
    found = 1'b0;
    for (int i = num_in - 1; i > int'(prio); i--) begin
      if (req[i]) begin
        nxt   = idx_t'(i);
        found = 1'b1;
      end
    end
    if (!found) begin
      for (int i = int'(prio); i >= 0; i--) begin
        if (req[i]) begin
          nxt = idx_t'(i);
        end
      end
    end
    return nxt;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "full rotation over all eight requesters";
      2:       return "fair skipping over a sparse request set";
      3:       return "locked decision under back-pressure";
      4:       return "flush of pointer and lock";
      5:       return "idle and stalled outputs";
      default: return "unknown";
    endcase
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH at %0t ns: test %0d %s is %0h, expected %0h",
             $time, cur_test, what, got, exp);
    errors_test++;
  endtask

  // compare all outputs a moment before the rising edge, then step the model over that edge
  task automatic check_cycle(input logic first_cycle, input logic exp_req, input idx_t exp_idx);
    req_vec_t held;
    logic     want_req;
    idx_t     want_idx;
    req_vec_t want_gnt;
    held     = model_lock ? model_cap : req_in;
    want_req = |held;
    want_idx = pick_winner(held, model_prio);
    want_gnt = (want_req && gnt_in) ? (req_vec_t'(1'b1) << want_idx) : '0;
    cycles_checked++;
    if (req_out !== want_req) report_mismatch("req_o", 32'(req_out), 32'(want_req));
    if (want_req && (idx_out !== want_idx)) report_mismatch("idx_o", 32'(idx_out), 32'(want_idx));
    if (want_req && (data_out !== data_in[want_idx])) begin
      report_mismatch("data_o", 32'(data_out), 32'(data_in[want_idx]));
    end
    if (gnt_out !== want_gnt) report_mismatch("gnt_o", 32'(gnt_out), 32'(want_gnt));
    if (fault !== 1'b0) begin
      report_mismatch("fault_o", 32'(fault), 32'd0);
      fault_errors++;
    end
    // the hand-derived table values only cover the first cycle of each row
    if (first_cycle && (req_out !== exp_req)) begin
      report_mismatch("req_o against table", 32'(req_out), 32'(exp_req));
    end
    if (first_cycle && exp_req && (idx_out !== exp_idx)) begin
      report_mismatch("idx_o against table", 32'(idx_out), 32'(exp_idx));
    end
    if (flush_in) begin
      model_prio = '0;
      model_lock = 1'b0;
      model_cap  = '0;
    end else begin
      if (want_req && gnt_in) model_prio = next_pointer(held, model_prio);
      model_lock = want_req && !gnt_in;
      model_cap  = model_lock ? held : '0;
    end
  endtask

  // after reset the arbiter should sit idle with nothing requested
  task automatic wait_outputs_idle(output logic expired);
    int waited;
    waited = 0;
    while (((req_out !== 1'b0) || (gnt_out !== '0)) && (waited < settle_limit)) begin
      @(negedge clk);
      waited++;
    end
    expired = (req_out !== 1'b0) || (gnt_out !== '0);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    seed           = 32'hb47d9e62;
    clk            = 1'b0;
    rst_n          = 1'b0;
    flush_in       = 1'b0;
    req_in         = '0;
    gnt_in         = 1'b0;
    data_in        = '0;
    model_prio     = '0;
    model_lock     = 1'b0;
    model_cap      = '0;
    cur_test       = 0;
    errors_test    = 0;
    errors_total   = 0;
    fault_errors   = 0;
    cycles_checked = 0;
    tests_run      = 0;
    tests_failed   = 0;
    load_vectors();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait_outputs_idle(timed_out);
    if (timed_out) begin
      $display("timeout: arbiter outputs did not go idle after reset");
      errors_total++;
    end else begin
      for (int r = 0; r < row_test.size(); r++) begin
        cur_test = row_test[r];
        for (int c = 0; c < row_cycles[r]; c++) begin
          // inputs change on the falling edge, fresh payloads every cycle
          req_in   = row_req[r];
          gnt_in   = row_gnt[r];
          flush_in = row_flush[r];
          for (int i = 0; i < num_in; i++) begin
            data_in[i] = data_t'($random(seed));
          end
          #(clk_half - 1);
          check_cycle(c == 0, row_exp_req[r], row_exp_idx[r]);
          @(negedge clk);
        end
        // a test ends where the next row belongs to another test
        if ((r == row_test.size() - 1) || (row_test[r+1] != row_test[r])) begin
          tests_run++;
          if (errors_test != 0) tests_failed++;
          $display("test %0d %s: %0d errors", cur_test, test_name(cur_test), errors_test);
          errors_total += errors_test;
          errors_test   = 0;
        end
      end
      tests_run++;
      if (fault_errors != 0) tests_failed++;
      $display("test 6 fault flag low in all %0d checked cycles: %0d errors",
               cycles_checked, fault_errors);
    end
    $display("tests run %0d, tests with errors %0d, cycles checked %0d, errors %0d",
             tests_run, tests_failed, cycles_checked, errors_total);
    if (errors_total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+testbench
common/tmr_arb_pkg.sv
arb_tree/arb_tree_lane.sv
arb_tree/rr_next_prio.sv
rtl/arb_lock_state.sv
rtl/tmr_rr_arb.sv
testbench/tb_tmr_rr_arb.sv

//--- Bender.yml
package:
  name: tmr_rr_arb

sources:
  # shared package first, then the lane logic and the top level
  - common/tmr_arb_pkg.sv
  - arb_tree/arb_tree_lane.sv
  - arb_tree/rr_next_prio.sv
  - rtl/arb_lock_state.sv
  - rtl/tmr_rr_arb.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_tmr_rr_arb.sv
